// File: logic/capture_pkg.sv
/*
  shared widths, bus structs and encodings of the capture design
  a timestamp (clock + index) must fit exactly one 32-bit register word
  CHANNELS is limited to 4 by the STATUS layout and the address map
*/
package capture_pkg;

  // sample and timestamp widths
  localparam int SAMPLE_WIDTH = 16;
  localparam int CLOCK_WIDTH = 18;
  localparam int SAMPLE_INDEX_WIDTH = 14;

  // AXI4-Lite geometry
  localparam int AXIL_ADDR_WIDTH = 8;
  localparam int AXIL_DATA_WIDTH = 32;
  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

  // per-channel register strides in bytes
  localparam int THRESH_STRIDE = 8;
  localparam int TSTAMP_STRIDE = 4;

  // input-word count in the upper bits, saved-word count in the lower bits
  typedef struct packed {
    logic [CLOCK_WIDTH-1:0] clock;
    logic [SAMPLE_INDEX_WIDTH-1:0] index;
  } timestamp_t;

  // master-driven channel fields
  typedef struct packed {
    logic [AXIL_ADDR_WIDTH-1:0] awaddr;
    logic awvalid;
    logic [AXIL_DATA_WIDTH-1:0] wdata;
    logic wvalid;
    logic bready;
    logic [AXIL_ADDR_WIDTH-1:0] araddr;
    logic arvalid;
    logic rready;
  } axil_req_t;

  // slave-driven channel fields
  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    logic [AXIL_DATA_WIDTH-1:0] rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef enum logic {WR_IDLE, WR_RESP} axil_state_e;

  typedef enum logic [7:0] {
    REG_CONTROL = 8'h00,
    REG_STATUS = 8'h04,
    REG_THRESH_BASE = 8'h10,
    REG_TSTAMP_BASE = 8'h40
  } reg_addr_e;

endpackage

// File: logic/event_fifo.sv
/*
  timestamp FIFO, FIFO_DEPTH must be a power of two and at least 2
  a push while full is lost and sets the sticky overflow flag
*/
module event_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic push,
  input  capture_pkg::timestamp_t push_data,
  input  logic pop,
  input  logic clear_overflow,
  output logic not_empty,
  output capture_pkg::timestamp_t head,
  output logic overflow
);
  import capture_pkg::*;

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  timestamp_t mem [FIFO_DEPTH];
  // pointers wrap on their own since the depth is a power of two
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0] count;
  logic full;
  logic do_push;
  logic do_pop;

  assign full = count == (PTR_WIDTH + 1)'(FIFO_DEPTH);
  assign not_empty = count != '0;
  assign do_push = push && !full;
  assign do_pop = pop && not_empty;
  // first-word fall-through
  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
      // a new drop wins over a clear in the same cycle
      if (push && full) begin
        overflow <= 1'b1;
      end else if (clear_overflow) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

// File: logic/sample_discriminator.sv
/*
  hysteresis discriminator, words pass 2 cycles after arrival while the state is high
  timestamps come 2 cycles after the triggering word, no back-pressure anywhere
  the clock counter is never cleared by capture_start and rolls over silently
*/
module sample_discriminator #(
  parameter int CHANNELS = 2,
  parameter int PARALLEL_SAMPLES = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic [CHANNELS-1:0][PARALLEL_SAMPLES*capture_pkg::SAMPLE_WIDTH-1:0] data_in,
  input  logic [CHANNELS-1:0] data_in_valid,
  input  logic [CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] threshold_high,
  input  logic [CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] threshold_low,
  input  logic capture_start,
  output logic [CHANNELS-1:0][PARALLEL_SAMPLES*capture_pkg::SAMPLE_WIDTH-1:0] data_out,
  output logic [CHANNELS-1:0] data_out_valid,
  output logic [CHANNELS-1:0] ts_valid,
  output capture_pkg::timestamp_t [CHANNELS-1:0] ts_data
);
  import capture_pkg::*;

  localparam int WORD_WIDTH = PARALLEL_SAMPLES * SAMPLE_WIDTH;

  // first data stage, lines up with the is_high update
  logic [CHANNELS-1:0][WORD_WIDTH-1:0] data_d;
  logic [CHANNELS-1:0] valid_d;
  // input-word counter and its copy aligned with sample_index
  logic [CHANNELS-1:0][CLOCK_WIDTH-1:0] timer;
  logic [CHANNELS-1:0][CLOCK_WIDTH-1:0] timer_d;
  // saved words since the last capture start
  logic [CHANNELS-1:0][SAMPLE_INDEX_WIDTH-1:0] sample_index;
  // hysteresis flop, delayed copy and edge
  logic [CHANNELS-1:0] is_high;
  logic [CHANNELS-1:0] is_high_d;
  logic [CHANNELS-1:0] rising;
  logic [CHANNELS-1:0] any_above_high;
  logic [CHANNELS-1:0] all_below_low;

  assign rising = is_high & ~is_high_d;

  // signed compare of every parallel sample against both thresholds
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      any_above_high[c] = 1'b0;
      all_below_low[c] = 1'b1;
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        if ($signed(data_in[c][s*SAMPLE_WIDTH +: SAMPLE_WIDTH]) > $signed(threshold_high[c])) begin
          any_above_high[c] = 1'b1;
        end
        // one sample above low keeps the state
        if ($signed(data_in[c][s*SAMPLE_WIDTH +: SAMPLE_WIDTH]) > $signed(threshold_low[c])) begin
          all_below_low[c] = 1'b0;
        end
      end
    end
  end

  // payload pipeline
  always_ff @(posedge clk) begin
    data_d <= data_in;
    data_out <= data_d;
    timer_d <= timer;
    for (int c = 0; c < CHANNELS; c++) begin
      // timer_d holds the count before the triggering word here
      ts_data[c].clock <= timer_d[c];
      ts_data[c].index <= sample_index[c];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_d <= '0;
      data_out_valid <= '0;
      ts_valid <= '0;
      is_high <= '0;
      is_high_d <= '0;
      timer <= '0;
      sample_index <= '0;
    end else begin
      valid_d <= data_in_valid;
      // state after the word decides whether it is kept
      data_out_valid <= valid_d & is_high;
      ts_valid <= rising;
      for (int c = 0; c < CHANNELS; c++) begin
        if (capture_start) begin
          // force a fresh edge if the pulse word is already high
          is_high_d[c] <= 1'b0;
          sample_index[c] <= '0;
          is_high[c] <= data_in_valid[c] && any_above_high[c];
        end else begin
          is_high_d[c] <= is_high[c];
          // count words as they leave the first stage with the state set
          if (valid_d[c] && is_high[c]) begin
            sample_index[c] <= sample_index[c] + 1'b1;
          end
          // SR behaviour, between the thresholds the state holds
          if (data_in_valid[c]) begin
            if (any_above_high[c]) begin
              is_high[c] <= 1'b1;
            end else if (all_below_low[c]) begin
              is_high[c] <= 1'b0;
            end
          end
        end
        // arrival counter runs across captures
        if (data_in_valid[c]) begin
          timer[c] <= timer[c] + 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/capture_regs.sv
/*
  AXI4-Lite register slave, one outstanding write and one outstanding read
  wstrb is not supported and every response is OKAY
  a TSTAMP read pops its FIFO, a STATUS read clears all overflow flags
*/
module capture_regs #(
  parameter int CHANNELS = 2
) (
  input  logic clk,
  input  logic reset,
  input  capture_pkg::axil_req_t axil_req,
  output capture_pkg::axil_rsp_t axil_rsp,
  output logic [CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] threshold_high,
  output logic [CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] threshold_low,
  output logic capture_start,
  input  logic [CHANNELS-1:0] fifo_not_empty,
  input  capture_pkg::timestamp_t [CHANNELS-1:0] fifo_head,
  input  logic [CHANNELS-1:0] fifo_overflow,
  output logic [CHANNELS-1:0] fifo_pop,
  output logic clear_overflow
);
  import capture_pkg::*;

  axil_state_e wr_state;
  logic wr_accept;
  logic rd_accept;
  logic rvalid;
  logic [AXIL_DATA_WIDTH-1:0] rdata;
  logic [AXIL_DATA_WIDTH-1:0] read_data;

  // address and data must arrive together
  assign wr_accept = (wr_state == WR_IDLE) && axil_req.awvalid && axil_req.wvalid;
  // next read only once the previous response has gone
  assign rd_accept = axil_req.arvalid && !rvalid;

  always_comb begin
    axil_rsp.awready = wr_accept;
    axil_rsp.wready = wr_accept;
    axil_rsp.bvalid = wr_state == WR_RESP;
    axil_rsp.bresp = AXIL_RESP_OKAY;
    axil_rsp.arready = rd_accept;
    axil_rsp.rvalid = rvalid;
    axil_rsp.rdata = rdata;
    axil_rsp.rresp = AXIL_RESP_OKAY;
  end

  // write sequencing, thresholds and the start pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state <= WR_IDLE;
      threshold_high <= '0;
      threshold_low <= '0;
      capture_start <= 1'b0;
    end else begin
      capture_start <= 1'b0;
      case (wr_state)
        WR_IDLE: begin
          if (wr_accept) begin
            wr_state <= WR_RESP;
            if (axil_req.awaddr == REG_CONTROL) begin
              capture_start <= axil_req.wdata[0];
            end
            for (int c = 0; c < CHANNELS; c++) begin
              if (axil_req.awaddr == 8'(REG_THRESH_BASE + THRESH_STRIDE * c)) begin
                threshold_high[c] <= axil_req.wdata[31:16];
                threshold_low[c] <= axil_req.wdata[15:0];
              end
            end
          end
        end
        WR_RESP: begin
          // response holds until the host takes it
          if (axil_req.bready) begin
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // read data mux, unmapped addresses read as zero
  always_comb begin
    read_data = '0;
    if (axil_req.araddr == REG_STATUS) begin
      read_data[CHANNELS-1:0] = fifo_not_empty;
      read_data[8 +: CHANNELS] = fifo_overflow;
    end
    for (int c = 0; c < CHANNELS; c++) begin
      if (axil_req.araddr == 8'(REG_THRESH_BASE + THRESH_STRIDE * c)) begin
        read_data = {threshold_high[c], threshold_low[c]};
      end
      // empty FIFO gives zero
      if (axil_req.araddr == 8'(REG_TSTAMP_BASE + TSTAMP_STRIDE * c) && fifo_not_empty[c]) begin
        read_data = fifo_head[c];
      end
    end
  end

  // side effects happen in the accept cycle
  always_comb begin
    clear_overflow = rd_accept && (axil_req.araddr == REG_STATUS);
    for (int c = 0; c < CHANNELS; c++) begin
      fifo_pop[c] = rd_accept && fifo_not_empty[c]
        && (axil_req.araddr == 8'(REG_TSTAMP_BASE + TSTAMP_STRIDE * c));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  // rdata stays put while rvalid is up
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata <= read_data;
    end
  end

endmodule

// File: logic/capture_top.sv
/*
  multi-channel sample capture with AXI4-Lite control
  CHANNELS at most 4, FIFO_DEPTH a power of two, the sample path has no ready
*/
module capture_top #(
  parameter int CHANNELS = 2,
  parameter int PARALLEL_SAMPLES = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic clk,
  input  logic reset,
  input  capture_pkg::axil_req_t axil_req,
  output capture_pkg::axil_rsp_t axil_rsp,
  input  logic [CHANNELS-1:0][PARALLEL_SAMPLES*capture_pkg::SAMPLE_WIDTH-1:0] data_in,
  input  logic [CHANNELS-1:0] data_in_valid,
  output logic [CHANNELS-1:0][PARALLEL_SAMPLES*capture_pkg::SAMPLE_WIDTH-1:0] data_out,
  output logic [CHANNELS-1:0] data_out_valid
);
  import capture_pkg::*;

  // register block to discriminator
  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] threshold_high;
  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] threshold_low;
  logic capture_start;
  // discriminator to FIFOs
  logic [CHANNELS-1:0] ts_valid;
  timestamp_t [CHANNELS-1:0] ts_data;
  // FIFOs to and from the register block
  logic [CHANNELS-1:0] fifo_not_empty;
  timestamp_t [CHANNELS-1:0] fifo_head;
  logic [CHANNELS-1:0] fifo_overflow;
  logic [CHANNELS-1:0] fifo_pop;
  logic clear_overflow;

  capture_regs #(
    .CHANNELS(CHANNELS)
  ) u_regs (
    .clk(clk),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .threshold_high(threshold_high),
    .threshold_low(threshold_low),
    .capture_start(capture_start),
    .fifo_not_empty(fifo_not_empty),
    .fifo_head(fifo_head),
    .fifo_overflow(fifo_overflow),
    .fifo_pop(fifo_pop),
    .clear_overflow(clear_overflow)
  );

  sample_discriminator #(
    .CHANNELS(CHANNELS),
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
  ) u_disc (
    .clk(clk),
    .reset(reset),
    .data_in(data_in),
    .data_in_valid(data_in_valid),
    .threshold_high(threshold_high),
    .threshold_low(threshold_low),
    .capture_start(capture_start),
    .data_out(data_out),
    .data_out_valid(data_out_valid),
    .ts_valid(ts_valid),
    .ts_data(ts_data)
  );

  // one event FIFO per channel, overflow clear is shared
  for (genvar c = 0; c < CHANNELS; c++) begin : g_fifo
    event_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
      .clk(clk),
      .reset(reset),
      .push(ts_valid[c]),
      .push_data(ts_data[c]),
      .pop(fifo_pop[c]),
      .clear_overflow(clear_overflow),
      .not_empty(fifo_not_empty[c]),
      .head(fifo_head[c]),
      .overflow(fifo_overflow[c])
    );
  end

endmodule

// File: sim/capture_tb.sv
/*
  directed testbench for capture_top with its default parameters
  a cycle model of the hysteresis rule predicts data_out and every timestamp
  TSTAMP and STATUS reads are only issued while the sample path is idle
*/
module capture_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import capture_pkg::*;

  localparam int CH = 2;
  localparam int PS = 4;
  localparam int DEPTH = 8;
  localparam int WORD = PS * SAMPLE_WIDTH;
  localparam int LIMIT = 100;
  localparam logic [7:0] ADDR_CONTROL = 8'h00;
  localparam logic [7:0] ADDR_STATUS = 8'h04;
  localparam logic [7:0] ADDR_THRESH = 8'h10;
  localparam logic [7:0] ADDR_TSTAMP = 8'h40;

  logic clk;
  logic reset;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic [CH-1:0][WORD-1:0] data_in;
  logic [CH-1:0] data_in_valid;
  logic [CH-1:0][WORD-1:0] data_out;
  logic [CH-1:0] data_out_valid;

  integer seed = 32'hacff;
  int pass_count = 0;
  int fail_count = 0;
  // rising edges seen so far and only read at negedge
  int cyc = 0;
  bit model_on = 0;
  // accepted register write that reaches the model at pend_cyc
  int pend_cyc = -1;
  logic [7:0] pend_addr;
  logic [31:0] pend_data;
  // model of each channel
  logic signed [SAMPLE_WIDTH-1:0] m_hi [CH];
  logic signed [SAMPLE_WIDTH-1:0] m_lo [CH];
  bit m_state [CH];
  int m_count [CH];
  int m_saved [CH];
  bit m_ovf [CH];
  logic [31:0] ts_q0 [$];
  logic [31:0] ts_q1 [$];
  // expected outputs one and two cycles ahead
  bit e1_v [CH];
  bit e2_v [CH];
  logic [WORD-1:0] e1_d [CH];
  logic [WORD-1:0] e2_d [CH];

  capture_top uut (
    .clk(clk),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .data_in(data_in),
    .data_in_valid(data_in_valid),
    .data_out(data_out),
    .data_out_valid(data_out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc = cyc + 1;

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string msg);
    if (actual !== expected) begin
      fail_count++;
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end else begin
      pass_count++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: the DUT gave no %s within %0d cycles", what, LIMIT);
    $display("TEST FAILED");
    $finish;
  endtask

  function automatic int ts_count(input int c);
    return (c == 0) ? ts_q0.size() : ts_q1.size();
  endfunction

  task automatic ts_push(input int c, input logic [31:0] ts);
    if (ts_count(c) == DEPTH) begin
      // full FIFO loses the event
      m_ovf[c] = 1'b1;
    end else if (c == 0) begin
      ts_q0.push_back(ts);
    end else begin
      ts_q1.push_back(ts);
    end
  endtask

  // empty FIFO reads as zero
  task automatic ts_pop(input int c, output logic [31:0] ts);
    ts = '0;
    if (ts_count(c) != 0) begin
      ts = (c == 0) ? ts_q0.pop_front() : ts_q1.pop_front();
    end
  endtask

  // hysteresis rule for the word now on the inputs, which the next edge samples
  task automatic model_word(input int c, input bit start);
    logic signed [SAMPLE_WIDTH-1:0] smp;
    bit above;
    bit below;
    bit v;
    bit nxt;
    bit rise;
    above = 1'b0;
    below = 1'b1;
    v = data_in_valid[c];
    for (int s = 0; s < PS; s++) begin
      smp = data_in[c][s*SAMPLE_WIDTH +: SAMPLE_WIDTH];
      if (smp > m_hi[c]) begin
        above = 1'b1;
      end
      if (smp > m_lo[c]) begin
        below = 1'b0;
      end
    end
    if (start) begin
      // start word decides the state alone and always counts as an edge
      m_saved[c] = 0;
      nxt = v && above;
      rise = nxt;
    end else begin
      nxt = m_state[c];
      if (v && above) begin
        nxt = 1'b1;
      end else if (v && below) begin
        nxt = 1'b0;
      end
      rise = nxt && !m_state[c];
    end
    if (rise) begin
      ts_push(c, {CLOCK_WIDTH'(m_count[c]), SAMPLE_INDEX_WIDTH'(m_saved[c])});
    end
    if (v && nxt) begin
      m_saved[c]++;
    end
    if (v) begin
      m_count[c]++;
    end
    m_state[c] = nxt;
    e1_v[c] = v && nxt;
    e1_d[c] = data_in[c];
  endtask

  task automatic apply_write(output bit start);
    start = 1'b0;
    if (pend_addr == ADDR_CONTROL) begin
      start = pend_data[0];
    end
    for (int c = 0; c < CH; c++) begin
      if (pend_addr == ADDR_THRESH + 8'(8 * c)) begin
        m_hi[c] = pend_data[31:16];
        m_lo[c] = pend_data[15:0];
      end
    end
  endtask

  // output checks and model step run at negedge where inputs and outputs are stable
  always @(negedge clk) begin : monitor
    bit start;
    start = 1'b0;
    if (model_on) begin
      for (int c = 0; c < CH; c++) begin
        check(data_out_valid[c], e2_v[c], $sformatf("data_out_valid ch%0d", c));
        if (e2_v[c]) begin
          check(data_out[c], e2_d[c], $sformatf("data_out ch%0d", c));
        end
        e2_v[c] = e1_v[c];
        e2_d[c] = e1_d[c];
      end
      if (cyc == pend_cyc) begin
        apply_write(start);
      end
      for (int c = 0; c < CH; c++) begin
        model_word(c, start);
      end
    end
  end

  task automatic send_word(input logic [CH-1:0][WORD-1:0] w, input logic [CH-1:0] v);
    @(posedge clk);
    data_in <= w;
    data_in_valid <= v;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) send_word('0, '0);
  endtask

  // sample 0 sits in the low bits
  function automatic logic [WORD-1:0] mk_word(input int s0, input int s1, input int s2,
                                              input int s3);
    return {16'(s3), 16'(s2), 16'(s1), 16'(s0)};
  endfunction

  function automatic logic [CH-1:0][WORD-1:0] both(input logic [WORD-1:0] w);
    return {w, w};
  endfunction

  // put drives one sample word in the cycle the register takes effect
  task automatic axil_write_word(input logic [7:0] addr, input logic [31:0] data,
                                 input bit put, input logic [CH-1:0][WORD-1:0] w,
                                 input logic [CH-1:0] v);
    int n;
    n = 0;
    @(posedge clk);
    axil_req.awaddr <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata <= data;
    axil_req.wvalid <= 1'b1;
    axil_req.bready <= 1'b1;
    @(negedge clk);
    // address and data channels are taken together
    while (!(axil_rsp.awready && axil_rsp.wready) && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n >= LIMIT) begin
      stop_on_timeout("awready and wready");
    end
    // accepted at the coming edge and seen by the sample path one cycle later
    pend_addr = addr;
    pend_data = data;
    pend_cyc = cyc + 1;
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid <= 1'b0;
    if (put) begin
      data_in <= w;
      data_in_valid <= v;
    end
    n = 0;
    @(negedge clk);
    while (!axil_rsp.bvalid && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n >= LIMIT) begin
      stop_on_timeout("bvalid");
    end
    check(axil_rsp.bresp, 2'b00, "bresp");
    @(posedge clk);
    axil_req.bready <= 1'b0;
    if (put) begin
      data_in_valid <= '0;
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    axil_write_word(addr, data, 1'b0, '0, '0);
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk);
    axil_req.araddr <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n >= LIMIT) begin
      stop_on_timeout("arready");
    end
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!axil_rsp.rvalid && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n >= LIMIT) begin
      stop_on_timeout("rvalid");
    end
    data = axil_rsp.rdata;
    check(axil_rsp.rresp, 2'b00, "rresp");
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic set_thresholds(input int c, input int hi, input int lo);
    axil_write(ADDR_THRESH + 8'(8 * c), {16'(hi), 16'(lo)});
  endtask

  task automatic read_ts(input int c, output logic [31:0] ts);
    logic [31:0] expected;
    axil_read(ADDR_TSTAMP + 8'(4 * c), ts);
    ts_pop(c, expected);
    check(ts, expected, $sformatf("timestamp ch%0d", c));
  endtask

  task automatic drain_ts(input int c);
    logic [31:0] ts;
    while (ts_count(c) > 0) begin
      read_ts(c, ts);
    end
  endtask

  task automatic read_status(output logic [31:0] st);
    logic [31:0] expected;
    expected = '0;
    for (int c = 0; c < CH; c++) begin
      expected[c] = ts_count(c) != 0;
      expected[8 + c] = m_ovf[c];
    end
    axil_read(ADDR_STATUS, st);
    check(st, expected, "STATUS");
    // sticky flags drop on this read
    for (int c = 0; c < CH; c++) begin
      m_ovf[c] = 1'b0;
    end
  endtask

  // word of one random kind with all samples low, one sample high or all in between
  task automatic random_word(output logic [WORD-1:0] w);
    logic [31:0] r;
    logic [1:0] kind;
    int pos;
    r = $random(seed);
    kind = r[1:0];
    for (int s = 0; s < PS; s++) begin
      r = $random(seed);
      if (kind == 2'd0) begin
        w[s*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'(-9000 - int'(r[9:0]));
      end else begin
        w[s*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'($signed(r[12:0]));
      end
    end
    if (kind == 2'd1) begin
      r = $random(seed);
      pos = r[1:0];
      w[pos*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'(9000 + int'(r[11:2]));
    end
  endtask

  task automatic report_test(input string name);
    $display("%s finished, %0d failed checks so far", name, fail_count);
  endtask

  task automatic test_registers();
    logic [31:0] d;
    axil_write(ADDR_THRESH, 32'h0400_fc00);
    axil_write(ADDR_THRESH + 8'd8, 32'h7fff_8000);
    axil_read(ADDR_THRESH, d);
    check(d, 32'h0400_fc00, "thresholds ch0");
    axil_read(ADDR_THRESH + 8'd8, d);
    check(d, 32'h7fff_8000, "thresholds ch1");
    axil_read(ADDR_STATUS, d);
    check(d, 32'h0, "STATUS after reset");
    report_test("register access");
  endtask

  task automatic test_hysteresis();
    set_thresholds(0, 100, -100);
    set_thresholds(1, 100, -100);
    send_word(both(mk_word(-200, -200, -200, -200)), 2'b11);
    // invalid words never move the state
    send_word(both(mk_word(500, 500, 500, 500)), 2'b00);
    send_word(both(mk_word(0, 0, 150, 0)), 2'b11);
    send_word(both(mk_word(99, -99, 0, 100)), 2'b11);
    send_word(both(mk_word(-500, -500, -500, -500)), 2'b00);
    send_word(both(mk_word(-100, 20, -100, -100)), 2'b11);
    // at the low threshold counts as below
    send_word(both(mk_word(-100, -100, -100, -100)), 2'b11);
    send_word(both(mk_word(50, 50, 50, 50)), 2'b11);
    idle(6);
    drain_ts(0);
    drain_ts(1);
    report_test("hysteresis gating");
  endtask

  task automatic test_timestamps();
    logic [31:0] ts;
    logic [31:0] st;
    repeat (3) begin
      send_word(both(mk_word(0, 300, 0, 0)), 2'b01);
      send_word(both(mk_word(20, 0, 0, 0)), 2'b01);
      send_word(both(mk_word(-300, -300, -300, -300)), 2'b01);
      send_word(both(mk_word(-300, -300, -300, -300)), 2'b01);
    end
    idle(6);
    read_status(st);
    check(st[0], 1'b1, "not-empty ch0 with events queued");
    repeat (3) read_ts(0, ts);
    read_ts(0, ts);
    check(ts, 32'h0, "TSTAMP read of empty FIFO");
    read_status(st);
    check(st[0], 1'b0, "not-empty ch0 after draining");
    report_test("timestamp content");
  endtask

  task automatic test_capture_start();
    logic [31:0] ts;
    logic [31:0] st;
    int clock_before;
    send_word(both(mk_word(-300, -300, -300, -300)), 2'b11);
    idle(2);
    clock_before = m_count[0];
    axil_write_word(ADDR_CONTROL, 32'h1, 1'b1, both(mk_word(0, 0, 500, 0)), 2'b01);
    send_word(both(mk_word(10, 10, 10, 10)), 2'b01);
    send_word(both(mk_word(10, 10, 10, 10)), 2'b01);
    idle(6);
    read_ts(0, ts);
    check(ts[SAMPLE_INDEX_WIDTH-1:0], 0, "index after capture start");
    check(ts[31:SAMPLE_INDEX_WIDTH], clock_before, "clock across capture start");
    read_status(st);
    report_test("capture start");
  endtask

  task automatic test_overflow();
    logic [31:0] ts;
    logic [31:0] st;
    repeat (DEPTH + 2) begin
      send_word({mk_word(0, 0, 0, 400), WORD'(0)}, 2'b10);
      send_word({mk_word(-400, -400, -400, -400), WORD'(0)}, 2'b10);
    end
    idle(6);
    read_status(st);
    check(st[9], 1'b1, "overflow ch1");
    check(st[8], 1'b0, "overflow ch0");
    repeat (DEPTH) read_ts(1, ts);
    read_status(st);
    check(st[9], 1'b0, "overflow ch1 after STATUS read");
    read_ts(0, ts);
    check(ts, 32'h0, "no events on ch0");
    report_test("overflow and independence");
  endtask

  task automatic test_random();
    logic [CH-1:0][WORD-1:0] w;
    logic [CH-1:0] v;
    logic [WORD-1:0] word;
    logic [31:0] r;
    logic [31:0] st;
    set_thresholds(0, 8000, -8000);
    set_thresholds(1, 8000, -8000);
    // 8 bursts of 25 words with the FIFOs drained in the gaps
    for (int burst = 0; burst < 8; burst++) begin
      for (int i = 0; i < 25; i++) begin
        for (int c = 0; c < CH; c++) begin
          random_word(word);
          w[c] = word;
          r = $random(seed);
          v[c] = r[0];
        end
        send_word(w, v);
      end
      idle(6);
      drain_ts(0);
      drain_ts(1);
      read_status(st);
    end
    report_test("random streams");
  endtask

  initial begin
    reset = 1'b1;
    axil_req = '0;
    data_in = '0;
    data_in_valid = '0;
    for (int c = 0; c < CH; c++) begin
      m_hi[c] = '0;
      m_lo[c] = '0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    model_on = 1'b1;
    test_registers();
    test_hysteresis();
    test_timestamps();
    test_capture_start();
    test_overflow();
    test_random();
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: capture_top.f
logic/capture_pkg.sv
logic/event_fifo.sv
logic/sample_discriminator.sv
logic/capture_regs.sv
logic/capture_top.sv
sim/capture_tb.sv
